// File: source/rnn_settings.svh
`ifndef RNN_SETTINGS_SVH
`define RNN_SETTINGS_SVH

// network sizes
`define EMBEDDING_SIZE 4
`define HIDDEN_SIZE    8
`define VOCAB_SIZE     76

// signed Q8.8 words
`define WORD_WIDTH 16
`define FRAC_BITS  8

`define ADDR_WIDTH 12

// weight memory map with the embedding table at address zero
`define IH_WEIGHT_BASE (`VOCAB_SIZE * `EMBEDDING_SIZE)
`define HH_WEIGHT_BASE (`IH_WEIGHT_BASE + `EMBEDDING_SIZE * `HIDDEN_SIZE)
`define IH_BIAS_BASE   (`HH_WEIGHT_BASE + `HIDDEN_SIZE * `HIDDEN_SIZE)
`define HH_BIAS_BASE   (`IH_BIAS_BASE + `HIDDEN_SIZE)

`endif

// File: source/rnn_pkg.sv
`include "rnn_settings.svh"

package rnn_pkg;

    typedef logic signed [`WORD_WIDTH-1:0] word_t; // Q8.8
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // one recurrence step walks these per neuron
    typedef enum logic [2:0]
    {
        idle,
        load_embedding,
        hh_weight,
        hh_bias,
        ih_weight,
        ih_bias,
        write_neuron
    } phase_t;

endpackage

// File: source/rnn_sequencer.sv
`timescale 1ns/1ps
`include "rnn_settings.svh"

module rnn_sequencer
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            rd_valid,
    output logic                            busy,
    output logic                            rd_en,
    output rnn_pkg::phase_t                 phase,
    output logic [$clog2(`HIDDEN_SIZE)-1:0] neuron_index,
    output logic [$clog2(`HIDDEN_SIZE)-1:0] operand_index,
    output logic                            acc_clear,
    output logic                            write_neuron,
    output logic                            commit,
    output logic                            step_done
);

    localparam int INDEX_WIDTH = $clog2(`HIDDEN_SIZE);
    localparam logic [INDEX_WIDTH-1:0] LAST_EMBEDDING = INDEX_WIDTH'(`EMBEDDING_SIZE - 1);
    localparam logic [INDEX_WIDTH-1:0] LAST_HIDDEN = INDEX_WIDTH'(`HIDDEN_SIZE - 1);

    logic pending;     // one read in flight
    logic data_ready;  // answer to our own read
    logic reads_phase;
    logic last_neuron;

    assign data_ready = rd_valid && pending;
    assign reads_phase = (phase != rnn_pkg::idle) && (phase != rnn_pkg::write_neuron);
    assign last_neuron = (neuron_index == LAST_HIDDEN);

    assign busy = (phase != rnn_pkg::idle);
    assign rd_en = reads_phase && !pending; // address is combinational from phase
    assign acc_clear = (phase == rnn_pkg::load_embedding) || (phase == rnn_pkg::write_neuron);
    assign write_neuron = (phase == rnn_pkg::write_neuron);

    // last word is merged into the copy, so commit shares the final write cycle
    assign commit = write_neuron && last_neuron;
    assign step_done = commit;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase <= rnn_pkg::idle;
            pending <= 1'b0;
            neuron_index <= '0;
            operand_index <= '0;
        end
        else
        begin
            if (rd_en)
                pending <= 1'b1;
            else if (data_ready)
                pending <= 1'b0;

            case (phase)
                rnn_pkg::idle:
                begin
                    if (start)
                    begin
                        phase <= rnn_pkg::load_embedding;
                        neuron_index <= '0;
                        operand_index <= '0;
                    end
                end
                rnn_pkg::load_embedding:
                begin
                    if (data_ready)
                    begin
                        if (operand_index == LAST_EMBEDDING)
                        begin
                            phase <= rnn_pkg::hh_weight;
                            operand_index <= '0;
                        end
                        else
                            operand_index <= operand_index + 1'b1;
                    end
                end
                rnn_pkg::hh_weight:
                begin
                    if (data_ready)
                    begin
                        if (operand_index == LAST_HIDDEN)
                        begin
                            phase <= rnn_pkg::hh_bias;
                            operand_index <= '0;
                        end
                        else
                            operand_index <= operand_index + 1'b1;
                    end
                end
                rnn_pkg::hh_bias:
                begin
                    if (data_ready)
                        phase <= rnn_pkg::ih_weight;
                end
                rnn_pkg::ih_weight:
                begin
                    if (data_ready)
                    begin
                        if (operand_index == LAST_EMBEDDING)
                        begin
                            phase <= rnn_pkg::ih_bias;
                            operand_index <= '0;
                        end
                        else
                            operand_index <= operand_index + 1'b1;
                    end
                end
                rnn_pkg::ih_bias:
                begin
                    if (data_ready)
                        phase <= rnn_pkg::write_neuron;
                end
                rnn_pkg::write_neuron:
                begin
                    if (last_neuron)
                    begin
                        phase <= rnn_pkg::idle; // step finished
                        neuron_index <= '0;
                    end
                    else
                    begin
                        phase <= rnn_pkg::hh_weight;
                        neuron_index <= neuron_index + 1'b1;
                    end
                end
                default:
                    phase <= rnn_pkg::idle;
            endcase
        end
    end

endmodule

// File: source/weight_address_gen.sv
`timescale 1ns/1ps
`include "rnn_settings.svh"

module weight_address_gen
(
    input  rnn_pkg::phase_t                 phase,
    input  logic [$clog2(`VOCAB_SIZE)-1:0]  token,
    input  logic [$clog2(`HIDDEN_SIZE)-1:0] neuron_index,
    input  logic [$clog2(`HIDDEN_SIZE)-1:0] operand_index,
    output rnn_pkg::addr_t                  rd_addr
);

    always_comb
    begin
        case (phase)
            rnn_pkg::load_embedding:
                rd_addr = rnn_pkg::addr_t'(token * `EMBEDDING_SIZE + operand_index);
            rnn_pkg::hh_weight: // row per neuron, column per old hidden word
                rd_addr = rnn_pkg::addr_t'(`HH_WEIGHT_BASE + neuron_index * `HIDDEN_SIZE
                                           + operand_index);
            rnn_pkg::hh_bias:
                rd_addr = rnn_pkg::addr_t'(`HH_BIAS_BASE + neuron_index);
            rnn_pkg::ih_weight:
                rd_addr = rnn_pkg::addr_t'(`IH_WEIGHT_BASE + neuron_index * `EMBEDDING_SIZE
                                           + operand_index);
            rnn_pkg::ih_bias:
                rd_addr = rnn_pkg::addr_t'(`IH_BIAS_BASE + neuron_index);
            default:
                rd_addr = '0; // idle and write cycles
        endcase
    end

endmodule

// File: source/mac_unit.sv
`timescale 1ns/1ps
`include "rnn_settings.svh"

module mac_unit
(
    input  logic            clk,
    input  logic            reset,
    input  logic            acc_clear,
    input  logic            rd_valid,
    input  rnn_pkg::phase_t phase,
    input  rnn_pkg::word_t  rd_data,
    input  rnn_pkg::word_t  operand,
    output rnn_pkg::word_t  acc
);

    logic signed [2*`WORD_WIDTH-1:0] product;
    logic signed [2*`WORD_WIDTH-1:0] product_scaled;
    rnn_pkg::word_t addend;
    logic add_en;

    assign product = rd_data * operand;           // full Q16.16
    assign product_scaled = product >>> `FRAC_BITS; // truncated back to Q8.8

    always_comb
    begin
        case (phase)
            rnn_pkg::hh_weight, rnn_pkg::ih_weight:
            begin
                addend = product_scaled[`WORD_WIDTH-1:0];
                add_en = rd_valid;
            end
            rnn_pkg::hh_bias, rnn_pkg::ih_bias:
            begin
                addend = rd_data; // bias goes in as is
                add_en = rd_valid;
            end
            default:
            begin
                addend = '0;
                add_en = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            acc <= '0;
        else if (acc_clear)
            acc <= '0;
        else if (add_en)
            acc <= acc + addend; // wraps at 16 bits
    end

endmodule

// File: source/state_bank.sv
`timescale 1ns/1ps
`include "rnn_settings.svh"

module state_bank
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rd_valid,
    input  rnn_pkg::phase_t                 phase,
    input  logic [$clog2(`HIDDEN_SIZE)-1:0] neuron_index,
    input  logic [$clog2(`HIDDEN_SIZE)-1:0] operand_index,
    input  rnn_pkg::word_t                  rd_data,
    input  rnn_pkg::word_t                  acc,
    input  logic                            write_neuron,
    input  logic                            commit,
    input  logic [$clog2(`HIDDEN_SIZE)-1:0] hidden_index,
    output rnn_pkg::word_t                  operand,
    output rnn_pkg::word_t                  hidden_word
);

    localparam int EMB_INDEX_WIDTH = $clog2(`EMBEDDING_SIZE);

    rnn_pkg::word_t embedding [`EMBEDDING_SIZE];
    rnn_pkg::word_t old_hidden [`HIDDEN_SIZE];
    rnn_pkg::word_t new_hidden [`HIDDEN_SIZE];
    logic [EMB_INDEX_WIDTH-1:0] emb_index;

    assign emb_index = operand_index[EMB_INDEX_WIDTH-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `EMBEDDING_SIZE; i++)
                embedding[i] <= '0;
            for (int i = 0; i < `HIDDEN_SIZE; i++)
            begin
                old_hidden[i] <= '0;
                new_hidden[i] <= '0;
            end
        end
        else
        begin
            if (rd_valid && phase == rnn_pkg::load_embedding)
                embedding[emb_index] <= rd_data;
            if (write_neuron)
                new_hidden[neuron_index] <= acc;
            // last neuron lands in the same edge, so take it straight from acc
            if (commit)
            begin
                for (int i = 0; i < `HIDDEN_SIZE; i++)
                    old_hidden[i] <= (write_neuron && i == int'(neuron_index)) ? acc
                                                                               : new_hidden[i];
            end
        end
    end

    always_comb
    begin
        case (phase)
            rnn_pkg::hh_weight: operand = old_hidden[operand_index];
            rnn_pkg::ih_weight: operand = embedding[emb_index];
            default:            operand = '0;
        endcase
    end

    assign hidden_word = old_hidden[hidden_index]; // readout of committed state

endmodule

// File: source/rnn_cell.sv
`timescale 1ns/1ps
`include "rnn_settings.svh"

module rnn_cell
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic [$clog2(`VOCAB_SIZE)-1:0]  token,
    input  rnn_pkg::word_t                  rd_data,
    input  logic                            rd_valid,
    input  logic [$clog2(`HIDDEN_SIZE)-1:0] hidden_index,
    output logic                            rd_en,
    output rnn_pkg::addr_t                  rd_addr,
    output logic                            busy,
    output logic                            step_done,
    output rnn_pkg::word_t                  hidden_word
);

    rnn_pkg::phase_t phase;
    logic [$clog2(`HIDDEN_SIZE)-1:0] neuron_index;
    logic [$clog2(`HIDDEN_SIZE)-1:0] operand_index;
    logic acc_clear;
    logic write_neuron;
    logic commit;
    rnn_pkg::word_t acc;
    rnn_pkg::word_t operand; // old hidden or embedding word

    rnn_sequencer i_sequencer
    (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .rd_valid      (rd_valid),
        .busy          (busy),
        .rd_en         (rd_en),
        .phase         (phase),
        .neuron_index  (neuron_index),
        .operand_index (operand_index),
        .acc_clear     (acc_clear),
        .write_neuron  (write_neuron),
        .commit        (commit),
        .step_done     (step_done)
    );

    weight_address_gen i_address_gen
    (
        .phase         (phase),
        .token         (token),
        .neuron_index  (neuron_index),
        .operand_index (operand_index),
        .rd_addr       (rd_addr)
    );

    mac_unit i_mac
    (
        .clk       (clk),
        .reset     (reset),
        .acc_clear (acc_clear),
        .rd_valid  (rd_valid),
        .phase     (phase),
        .rd_data   (rd_data),
        .operand   (operand),
        .acc       (acc)
    );

    state_bank i_state_bank
    (
        .clk           (clk),
        .reset         (reset),
        .rd_valid      (rd_valid),
        .phase         (phase),
        .neuron_index  (neuron_index),
        .operand_index (operand_index),
        .rd_data       (rd_data),
        .acc           (acc),
        .write_neuron  (write_neuron),
        .commit        (commit),
        .hidden_index  (hidden_index),
        .operand       (operand),
        .hidden_word   (hidden_word)
    );

endmodule

// File: test/weight_memory_model.sv
`timescale 1ns/1ps
`include "rnn_settings.svh"

module weight_memory_model
#(
    parameter int SEED = 1
)
(
    input  logic           clk,
    input  logic           reset,
    input  logic           rd_en,
    input  rnn_pkg::addr_t rd_addr,
    output logic           rd_valid,
    output rnn_pkg::word_t rd_data
);

    localparam int MEM_DEPTH = 1 << `ADDR_WIDTH;

    rnn_pkg::word_t mem [MEM_DEPTH];
    rnn_pkg::addr_t addr_q;
    int wait_count; // cycles left before the answer

    initial
    begin
        rd_valid = 1'b0;
        rd_data = '0;
        addr_q = '0;
        wait_count = 0;
        void'($urandom(SEED)); // the one seed of the run
        for (int a = 0; a < MEM_DEPTH; a++)
            mem[a] = rnn_pkg::word_t'(int'($urandom_range(255, 0)) - 128); // about +-0.5
    end

    // acts mid-cycle, so the DUT sees a stable answer at its rising edge
    always @(negedge clk)
    begin
        rd_valid <= 1'b0;
        if (reset)
            wait_count <= 0; // drop any read in flight
        else if (rd_en)
        begin
            addr_q <= rd_addr;
            wait_count <= int'($urandom_range(6, 1));
        end
        else if (wait_count != 0)
        begin
            wait_count <= wait_count - 1;
            if (wait_count == 1)
            begin
                rd_valid <= 1'b1;
                rd_data <= mem[addr_q];
            end
        end
    end

endmodule

// File: test/rnn_cell_tb.sv
`timescale 1ns/1ps
`include "rnn_settings.svh"

module rnn_cell_tb;

    localparam int INDEX_WIDTH = $clog2(`HIDDEN_SIZE);
    localparam int TOKEN_WIDTH = $clog2(`VOCAB_SIZE);
    localparam int READS_PER_STEP = `EMBEDDING_SIZE
                                    + `HIDDEN_SIZE * (`HIDDEN_SIZE + `EMBEDDING_SIZE + 2);
    localparam int ADDR_LIMIT = `HH_BIAS_BASE + `HIDDEN_SIZE;
    localparam int STEP_TIMEOUT = 4000; // worst case of a step is under 1000 cycles

    logic clk = 1'b0;
    logic reset;
    logic start;
    logic [TOKEN_WIDTH-1:0] token;
    logic [INDEX_WIDTH-1:0] hidden_index;
    logic rd_en;
    rnn_pkg::addr_t rd_addr;
    logic rd_valid;
    rnn_pkg::word_t rd_data;
    logic busy;
    logic step_done;
    rnn_pkg::word_t hidden_word;

    rnn_pkg::word_t model_hidden [`HIDDEN_SIZE]; // expected old hidden state
    int expected_addr [$]; // addresses still due in this step
    logic outstanding = 1'b0;
    int reads_in_step = 0;
    int done_count = 0;

    always #50 clk = ~clk;

    rnn_cell i_dut
    (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .token        (token),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .hidden_index (hidden_index),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .busy         (busy),
        .step_done    (step_done),
        .hidden_word  (hidden_word)
    );

    weight_memory_model #(.SEED(61)) i_mem
    (
        .clk      (clk),
        .reset    (reset),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_low(string name, logic value);
        assert (value == 1'b0)
        else
        begin
            $display("** Error: %s = 0x%h, expected 0x0", name, value);
            stop_with_failure();
        end
    endtask

    // read port protocol and read count per step
    always @(posedge clk)
    begin
        if (reset)
        begin
            outstanding = 1'b0;
            reads_in_step = 0;
            expected_addr.delete();
        end
        else
        begin
            if (rd_en)
            begin
                assert (!outstanding)
                else
                begin
                    $display("rd_en was raised while a read was still outstanding");
                    stop_with_failure();
                end
                assert (int'(rd_addr) < ADDR_LIMIT)
                else
                begin
                    $display("** Error: rd_addr = 0x%h, expected below 0x%h", rd_addr, ADDR_LIMIT);
                    stop_with_failure();
                end
                assert (expected_addr.size() != 0)
                else
                begin
                    $display("rd_en was raised after the last read of the step");
                    stop_with_failure();
                end
                assert (int'(rd_addr) == expected_addr[0])
                else
                begin
                    $display("** Error: rd_addr = 0x%h, expected 0x%h", rd_addr, expected_addr[0]);
                    stop_with_failure();
                end
                void'(expected_addr.pop_front());
                reads_in_step++;
            end
            outstanding = rd_en ? 1'b1 : (rd_valid ? 1'b0 : outstanding);
            if (step_done)
            begin
                assert (reads_in_step == READS_PER_STEP)
                else
                begin
                    $display("** Error: reads per step = 0x%h, expected 0x%h",
                             reads_in_step, READS_PER_STEP);
                    stop_with_failure();
                end
                reads_in_step = 0;
                done_count++;
            end
        end
    end

    function automatic rnn_pkg::word_t q_multiply(rnn_pkg::word_t a, rnn_pkg::word_t b);
        int product;
        product = int'(a) * int'(b);
        return rnn_pkg::word_t'(product >>> `FRAC_BITS); // truncate toward minus infinity
    endfunction

    function automatic rnn_pkg::word_t weight_at(int addr);
        return i_mem.mem[addr];
    endfunction

    function automatic int next_token(int previous);
        return (previous + 1 + int'($urandom_range(`VOCAB_SIZE - 2, 0))) % `VOCAB_SIZE;
    endfunction

    // read order of one step from the address map
    task automatic queue_step_addresses(int tok);
        expected_addr.delete();
        for (int k = 0; k < `EMBEDDING_SIZE; k++)
            expected_addr.push_back(tok * `EMBEDDING_SIZE + k);
        for (int n = 0; n < `HIDDEN_SIZE; n++)
        begin
            for (int j = 0; j < `HIDDEN_SIZE; j++)
                expected_addr.push_back(`HH_WEIGHT_BASE + n * `HIDDEN_SIZE + j);
            expected_addr.push_back(`HH_BIAS_BASE + n);
            for (int k = 0; k < `EMBEDDING_SIZE; k++)
                expected_addr.push_back(`IH_WEIGHT_BASE + n * `EMBEDDING_SIZE + k);
            expected_addr.push_back(`IH_BIAS_BASE + n);
        end
    endtask

    task automatic model_step(int tok);
        rnn_pkg::word_t emb [`EMBEDDING_SIZE];
        rnn_pkg::word_t new_state [`HIDDEN_SIZE];
        rnn_pkg::word_t sum;
        for (int k = 0; k < `EMBEDDING_SIZE; k++)
            emb[k] = weight_at(tok * `EMBEDDING_SIZE + k);
        for (int n = 0; n < `HIDDEN_SIZE; n++)
        begin
            sum = '0;
            for (int j = 0; j < `HIDDEN_SIZE; j++)
                sum = sum + q_multiply(weight_at(`HH_WEIGHT_BASE + n * `HIDDEN_SIZE + j),
                                       model_hidden[j]);
            sum = sum + weight_at(`HH_BIAS_BASE + n);
            for (int k = 0; k < `EMBEDDING_SIZE; k++)
                sum = sum + q_multiply(weight_at(`IH_WEIGHT_BASE + n * `EMBEDDING_SIZE + k),
                                       emb[k]);
            new_state[n] = sum + weight_at(`IH_BIAS_BASE + n); // wraps at 16 bits
        end
        for (int n = 0; n < `HIDDEN_SIZE; n++)
            model_hidden[n] = new_state[n];
    endtask

    task automatic clear_model();
        for (int n = 0; n < `HIDDEN_SIZE; n++)
            model_hidden[n] = '0;
    endtask

    task automatic check_hidden_state();
        for (int i = 0; i < `HIDDEN_SIZE; i++)
        begin
            @(negedge clk);
            hidden_index <= INDEX_WIDTH'(i);
            @(negedge clk);
            assert (hidden_word == model_hidden[i])
            else
            begin
                $display("** Error: hidden_word[%0d] = 0x%h, expected 0x%h",
                         i, hidden_word, model_hidden[i]);
                stop_with_failure();
            end
        end
    endtask

    task automatic reset_dut(int cycles);
        @(negedge clk);
        reset <= 1'b1;
        start <= 1'b0;
        repeat (cycles) @(negedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_for_busy();
        int cycles;
        cycles = 0;
        while (!busy && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (busy)
        else
        begin
            $display("busy did not rise after an accepted start");
            stop_with_failure();
        end
    endtask

    task automatic wait_for_step_done();
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (!step_done && cycles < STEP_TIMEOUT);
        assert (step_done)
        else
        begin
            $display("timed out waiting for step_done");
            stop_with_failure();
        end
        @(negedge clk);
        check_low("busy", busy); // falls with step_done
    endtask

    task automatic wait_for_reads(int count);
        int cycles;
        cycles = 0;
        while (reads_in_step < count && cycles < STEP_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (reads_in_step >= count)
        else
        begin
            $display("timed out waiting for reads in the middle of a step");
            stop_with_failure();
        end
    endtask

    task automatic start_step(int tok);
        @(negedge clk);
        queue_step_addresses(tok);
        token <= TOKEN_WIDTH'(tok);
        start <= 1'b1;
        @(negedge clk);
        start <= 1'b0;
        wait_for_busy();
    endtask

    task automatic run_step(int tok);
        start_step(tok);
        wait_for_step_done();
        model_step(tok);
        check_hidden_state();
    endtask

    initial
    begin
        int tok;
        int done_before;
        reset = 1'b1;
        start = 1'b0;
        token = '0;
        hidden_index = '0;
        tok = 0;
        clear_model();
        reset_dut(5);

        // idle outputs and zero state after reset
        @(negedge clk);
        check_low("busy", busy);
        check_low("step_done", step_done);
        check_low("rd_en", rd_en);
        check_hidden_state();

        // one step then three more with changing tokens through the recurrence
        for (int s = 0; s < 4; s++)
        begin
            tok = next_token(tok);
            run_step(tok);
        end

        // second start while busy must be dropped
        done_before = done_count;
        tok = next_token(tok);
        start_step(tok);
        repeat (3) @(negedge clk);
        start <= 1'b1;
        @(negedge clk);
        start <= 1'b0;
        wait_for_step_done();
        model_step(tok);
        repeat (20) @(negedge clk);
        check_low("busy", busy);
        assert (done_count == done_before + 1)
        else
        begin
            $display("** Error: step_done count = 0x%h, expected 0x%h",
                     done_count - done_before, 1);
            stop_with_failure();
        end
        check_hidden_state();

        // reset in the middle of a step
        tok = next_token(tok);
        start_step(tok);
        wait_for_reads(40);
        reset_dut(2);
        @(negedge clk);
        check_low("busy", busy);
        clear_model();
        check_hidden_state();
        tok = next_token(tok);
        run_step(tok); // model restarts from zero

        $display("Regression passed");
        $finish;
    end

endmodule

// File: rnn_cell.f
+incdir+source
source/rnn_pkg.sv
source/rnn_sequencer.sv
source/weight_address_gen.sv
source/mac_unit.sv
source/state_bank.sv
source/rnn_cell.sv
test/weight_memory_model.sv
test/rnn_cell_tb.sv

// File: Makefile
TOP = rnn_cell_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module rnn_cell -f rnn_cell.f

sim:
	verilator --binary --assert --top-module $(TOP) -f rnn_cell.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
